//--- all.f
hw/cube_pkg.sv
hw/spi_bus_arbiter.sv
hw/spi_memory_slave.sv
hw/vram_access_ctrl.sv
hw/vram_port.sv
hw/cube_spi_top.sv
verif/sram_model.sv
verif/tb_cube_spi_top.sv

//--- hw/cube_pkg.sv
`default_nettype none

package cube_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data and address widths.
  //////////////////////////////////////////////////////////////////////

  // One host byte.
  localparam int BYTE_W = 8;
  // One VRAM word, two byte lanes.
  localparam int WORD_W = 16;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;

  // Host side byte address.
  typedef logic [15:0] byte_addr_t;
  // VRAM word address, top bit stays clear.
  typedef logic [15:0] vram_addr_t;
  // Byte enables, bit 0 is the low lane.
  typedef logic [1:0]  be_t;

  // Command byte bit that selects a write transaction.
  localparam int SPI_CMD_WRITE = 7;

endpackage

`default_nettype wire

//--- hw/cube_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module cube_spi_top
  import cube_pkg::*;
#(
  parameter int VRAM_WAIT_CYCLES = 2,
  parameter int SCK_SYNC_STAGES  = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ss_n,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  input  logic       alt_ss_n,
  input  logic       alt_sck,
  input  logic       alt_mosi,
  output logic       alt_miso,
  output logic       vram_en_n,
  output logic       vram_rd_n,
  output logic       vram_wr_n,
  output be_t        vram_be_n,
  output vram_addr_t vram_addr,
  inout  wire word_t vram_data
);

  // Arbitrated SPI lines.
  logic mem_ss_n, mem_sck, mem_mosi, mem_miso;

  // Byte request path.
  logic       wr_stb, rd_stb, rd_valid;
  byte_addr_t byte_addr;
  byte_t      wr_data, rd_data;

  // Word access levels, active high.
  logic       ctrl_en, ctrl_rd, ctrl_wr;
  be_t        ctrl_be;
  vram_addr_t ctrl_addr;
  word_t      ctrl_wdata, ctrl_rdata;

  spi_bus_arbiter u_arbiter (
    .clk, .reset, .ss_n, .sck, .mosi, .miso, .alt_ss_n, .alt_sck, .alt_mosi, .alt_miso,
    .mem_ss_n, .mem_sck, .mem_mosi, .mem_miso
  );

  spi_memory_slave #(.SCK_SYNC_STAGES(SCK_SYNC_STAGES)) u_slave (
    .clk, .reset, .ss_n(mem_ss_n), .sck(mem_sck), .mosi(mem_mosi), .miso(mem_miso),
    .wr_stb, .rd_stb, .byte_addr, .wr_data, .rd_valid, .rd_data
  );

  vram_access_ctrl #(.VRAM_WAIT_CYCLES(VRAM_WAIT_CYCLES)) u_ctrl (
    .clk, .reset, .wr_stb, .rd_stb, .byte_addr, .wr_data, .rd_valid, .rd_data,
    .vram_en(ctrl_en), .vram_rd(ctrl_rd), .vram_wr(ctrl_wr), .vram_be(ctrl_be),
    .vram_addr(ctrl_addr), .vram_wdata(ctrl_wdata), .vram_rdata(ctrl_rdata)
  );

  vram_port u_port (
    .clk, .reset, .vram_en(ctrl_en), .vram_rd(ctrl_rd), .vram_wr(ctrl_wr),
    .vram_be(ctrl_be), .vram_addr(ctrl_addr), .vram_wdata(ctrl_wdata),
    .vram_rdata(ctrl_rdata), .vram_en_n, .vram_rd_n, .vram_wr_n, .vram_be_n,
    .vram_addr_pin(vram_addr), .vram_data
  );

endmodule

`default_nettype wire

//--- hw/spi_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bus_arbiter (
  input  logic clk,
  input  logic reset,
  input  logic ss_n,
  input  logic sck,
  input  logic mosi,
  output logic miso,
  input  logic alt_ss_n,
  input  logic alt_sck,
  input  logic alt_mosi,
  output logic alt_miso,
  output logic mem_ss_n,
  output logic mem_sck,
  output logic mem_mosi,
  input  logic mem_miso
);

  // Owner encoding, one bit per bus.
  localparam logic [1:0] OWN_NONE = 2'b00;
  localparam logic [1:0] OWN_PRI  = 2'b01;
  localparam logic [1:0] OWN_ALT  = 2'b10;

  logic [1:0] owner;

  // Primary bus wins a tie, the owner keeps it until its select rises.
  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= OWN_NONE;
    end else begin
      case (owner)
        OWN_PRI: if (ss_n) owner <= OWN_NONE;
        OWN_ALT: if (alt_ss_n) owner <= OWN_NONE;
        default: begin
          if (!ss_n) owner <= OWN_PRI;
          else if (!alt_ss_n) owner <= OWN_ALT;
        end
      endcase
    end
  end

  // Owner lines to the slave. Select held high with no owner.
  assign mem_ss_n = owner[0] ? ss_n : (owner[1] ? alt_ss_n : 1'b1);
  assign mem_sck  = owner[0] ? sck  : (owner[1] ? alt_sck  : 1'b0);
  assign mem_mosi = owner[0] ? mosi : (owner[1] ? alt_mosi : 1'b0);

  // Only the owner hears the slave.
  assign miso     = owner[0] & mem_miso;
  assign alt_miso = owner[1] & mem_miso;

endmodule

`default_nettype wire

//--- hw/spi_memory_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_memory_slave
  import cube_pkg::*;
#(
  parameter int SCK_SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       ss_n,
  input  logic       sck,
  input  logic       mosi,
  output logic       miso,
  output logic       wr_stb,
  output logic       rd_stb,
  output byte_addr_t byte_addr,
  output byte_t      wr_data,
  input  logic       rd_valid,
  input  byte_t      rd_data
);

  // Frame phases, one per byte type.
  typedef enum logic [1:0] {PH_CMD, PH_ADDR_HI, PH_ADDR_LO, PH_DATA} phase_t;

  logic [SCK_SYNC_STAGES-1:0] sck_sync;
  logic [SCK_SYNC_STAGES-1:0] ss_sync;
  logic [SCK_SYNC_STAGES-1:0] mosi_sync;
  logic                       sck_prev;
  logic                       sck_s;
  logic                       ss_s;
  logic                       mosi_s;
  logic                       sck_rise;
  logic                       sck_fall;
  logic                       byte_done;
  phase_t                     phase;
  logic [2:0]                 bit_cnt;
  logic                       is_write;
  byte_t                      shift_in;
  byte_t                      rx_byte;
  byte_t                      tx_shift;

  //////////////////////////////////////////////////////////////////////
  // Pin synchronizers and SCK edge detection.
  //////////////////////////////////////////////////////////////////////

  // Pins enter at bit 0 and leave at the top bit.
  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync  <= '0;
      ss_sync   <= '1;
      mosi_sync <= '0;
      sck_prev  <= 1'b0;
    end else begin
      sck_sync  <= (sck_sync << 1) | SCK_SYNC_STAGES'(sck);
      ss_sync   <= (ss_sync << 1) | SCK_SYNC_STAGES'(ss_n);
      mosi_sync <= (mosi_sync << 1) | SCK_SYNC_STAGES'(mosi);
      sck_prev  <= sck_s;
    end
  end

  assign sck_s    = sck_sync[SCK_SYNC_STAGES-1];
  assign ss_s     = ss_sync[SCK_SYNC_STAGES-1];
  assign mosi_s   = mosi_sync[SCK_SYNC_STAGES-1];
  assign sck_rise = sck_s & ~sck_prev;
  assign sck_fall = ~sck_s & sck_prev;

  // Byte with the current MOSI bit appended.
  assign rx_byte   = {shift_in[BYTE_W-2:0], mosi_s};
  // Eighth rising edge of a byte.
  assign byte_done = sck_rise && (bit_cnt == 3'd7);

  // MSB first out of the transmit shifter.
  assign miso = tx_shift[BYTE_W-1];

  //////////////////////////////////////////////////////////////////////
  // Frame decoder.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase    <= PH_CMD;
      bit_cnt  <= '0;
      is_write <= 1'b0;
      wr_stb   <= 1'b0;
      rd_stb   <= 1'b0;
      tx_shift <= '0;
    end else begin
      wr_stb <= 1'b0;
      rd_stb <= 1'b0;
      if (ss_s) begin
        // Deselected, wait for the next command byte.
        phase    <= PH_CMD;
        bit_cnt  <= '0;
        tx_shift <= '0;
      end else begin
        if (sck_rise) bit_cnt <= bit_cnt + 3'd1;
        if (byte_done) begin
          case (phase)
            PH_CMD: begin
              is_write <= rx_byte[SPI_CMD_WRITE];
              phase    <= PH_ADDR_HI;
            end
            PH_ADDR_HI: phase <= PH_ADDR_LO;
            PH_ADDR_LO: begin
              // Prefetch the first read byte.
              phase  <= PH_DATA;
              rd_stb <= ~is_write;
            end
            default: begin
              wr_stb <= is_write;
              rd_stb <= ~is_write;
            end
          endcase
        end
        // The fall after a byte boundary keeps the new MSB in place.
        if (sck_fall && (bit_cnt != 3'd0)) tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
        if (rd_valid) tx_shift <= rd_data;
      end
    end
  end

  // Receive shifter, address and write byte.
  always_ff @(posedge clk) begin
    if (sck_rise) shift_in <= rx_byte;
    // Address steps once each strobe has gone out.
    if (wr_stb || rd_stb) byte_addr <= byte_addr + 16'd1;
    if (byte_done) begin
      if (phase == PH_ADDR_HI) byte_addr <= {rx_byte, byte_addr[7:0]};
      if (phase == PH_ADDR_LO) byte_addr <= {byte_addr[15:8], rx_byte};
      wr_data <= rx_byte;
    end
  end

endmodule

`default_nettype wire

//--- hw/vram_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vram_access_ctrl
  import cube_pkg::*;
#(
  parameter int VRAM_WAIT_CYCLES = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       wr_stb,
  input  logic       rd_stb,
  input  byte_addr_t byte_addr,
  input  byte_t      wr_data,
  output logic       rd_valid,
  output byte_t      rd_data,
  output logic       vram_en,
  output logic       vram_rd,
  output logic       vram_wr,
  output be_t        vram_be,
  output vram_addr_t vram_addr,
  output word_t      vram_wdata,
  input  word_t      vram_rdata
);

  // Wide enough to count up to the last wait cycle.
  localparam int CNT_W = $clog2(VRAM_WAIT_CYCLES + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_CAPTURE, ST_RECOVER} state_t;

  state_t           state;
  logic [CNT_W-1:0] wait_cnt;
  logic             is_read;
  byte_addr_t       addr_q;
  byte_t            data_q;
  logic             access;

  //////////////////////////////////////////////////////////////////////
  // Access sequencer.
  //////////////////////////////////////////////////////////////////////

  // Strobes outside idle are dropped.
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          wait_cnt <= '0;
          if (wr_stb || rd_stb) state <= ST_ACCESS;
        end
        ST_ACCESS: begin
          // Controls held for the full wait count.
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == CNT_W'(VRAM_WAIT_CYCLES - 1)) state <= ST_CAPTURE;
        end
        // Port takes its last data sample here.
        ST_CAPTURE: state <= ST_RECOVER;
        default: begin
          rd_valid <= is_read;
          state    <= ST_IDLE;
        end
      endcase
    end
  end

  // Request latch, loaded only when a new access starts.
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && (wr_stb || rd_stb)) begin
      is_read <= rd_stb;
      addr_q  <= byte_addr;
      data_q  <= wr_data;
    end
    // Lane picked by the low address bit.
    if (state == ST_RECOVER) begin
      rd_data <= addr_q[0] ? vram_rdata[WORD_W-1:BYTE_W] : vram_rdata[BYTE_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // VRAM control levels.
  //////////////////////////////////////////////////////////////////////

  assign access  = (state == ST_ACCESS);
  assign vram_en = access;
  assign vram_rd = access & is_read;
  assign vram_wr = access & ~is_read;

  // One-hot lane enable, high lane for odd bytes.
  assign vram_be = access ? (addr_q[0] ? 2'b10 : 2'b01) : 2'b00;

  // Byte address down to word address.
  assign vram_addr = {1'b0, addr_q[15:1]};

  // Same byte on both lanes, the enable picks one.
  assign vram_wdata = {data_q, data_q};

endmodule

`default_nettype wire

//--- hw/vram_port.sv
`timescale 1ns/1ps
`default_nettype none

module vram_port
  import cube_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       vram_en,
  input  logic       vram_rd,
  input  logic       vram_wr,
  input  be_t        vram_be,
  input  vram_addr_t vram_addr,
  input  word_t      vram_wdata,
  output word_t      vram_rdata,
  output logic       vram_en_n,
  output logic       vram_rd_n,
  output logic       vram_wr_n,
  output be_t        vram_be_n,
  output vram_addr_t vram_addr_pin,
  inout  wire word_t vram_data
);

  word_t wdata_q;

  // Active-low controls go out from flops.
  always_ff @(posedge clk) begin
    if (reset) begin
      vram_en_n <= 1'b1;
      vram_rd_n <= 1'b1;
      vram_wr_n <= 1'b1;
      vram_be_n <= 2'b11;
    end else begin
      vram_en_n <= ~vram_en;
      vram_rd_n <= ~vram_rd;
      vram_wr_n <= ~vram_wr;
      vram_be_n <= ~vram_be;
    end
  end

  // Address and write data flops, plus read sampling.
  always_ff @(posedge clk) begin
    vram_addr_pin <= vram_addr;
    wdata_q       <= vram_wdata;
    // Last sample of the read is the one kept.
    if (!vram_rd_n) vram_rdata <= vram_data;
  end

  // Bus driven only during a write.
  assign vram_data = (!vram_en_n && !vram_wr_n) ? wdata_q : {WORD_W{1'bz}};

endmodule

`default_nettype wire

//--- verif/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
  parameter logic [15:0] FILL_KEY = 16'h0000
) (
  input  logic        cs_n,
  input  logic        oe_n,
  input  logic        we_n,
  input  logic [1:0]  be_n,
  input  logic [15:0] addr,
  inout  wire  [15:0] data
);

  logic [15:0] mem [0:65535];

  // Power-up content, every word keyed by its own address.
  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 16'(i) ^ FILL_KEY;
    end
  end

  // Read drives the whole word while the write strobe is idle.
  assign data = (!cs_n && !oe_n && we_n) ? mem[addr] : 16'hzzzz;

  // Pins all move on one clock edge.
  // The short delay lets them settle before a lane is stored.
  always @(cs_n or we_n or be_n or addr or data) begin
    #1;
    if (!cs_n && !we_n) begin
      if (!be_n[0]) mem[addr][7:0] = data[7:0];
      if (!be_n[1]) mem[addr][15:8] = data[15:8];
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_cube_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cube_spi_top
  import cube_pkg::*;
;

  localparam int     WAIT_CYCLES = 2;
  localparam int     SYNC_STAGES = 2;
  localparam int     N_BURSTS    = 4;
  localparam int     MAX_LEN     = 8;
  localparam word_t  FILL_KEY    = 16'h5a3c;
  // Bursts on both buses, lane test and contention round.
  localparam int     NUM_FRAMES  = 4 * N_BURSTS + 8;
  localparam int     FRAME_BYTES = 3 + MAX_LEN;
  localparam int     SCK_PERIOD  = 16 * 20;
  localparam int     TIMEOUT_NS  = NUM_FRAMES * FRAME_BYTES * 8 * SCK_PERIOD * 2;

  logic       clk   = 1'b0;
  logic       reset = 1'b1;
  // Index 0 is the primary bus, index 1 the alternate bus.
  logic [1:0] ss_n_bus = 2'b11;
  logic [1:0] sck_bus  = 2'b00;
  logic [1:0] mosi_bus = 2'b00;
  wire  [1:0] miso_bus;
  logic       vram_en_n, vram_rd_n, vram_wr_n;
  be_t        vram_be_n;
  vram_addr_t vram_addr;
  wire word_t vram_data;

  byte_t       ref_mem [0:65535];
  int          byte_errors  = 0;
  int          level_errors = 0;
  int          count_errors = 0;
  int          run_len      = 0;
  int unsigned seed_val;

  cube_spi_top #(.VRAM_WAIT_CYCLES(WAIT_CYCLES), .SCK_SYNC_STAGES(SYNC_STAGES)) dut (
    .clk, .reset, .ss_n(ss_n_bus[0]), .sck(sck_bus[0]), .mosi(mosi_bus[0]),
    .miso(miso_bus[0]), .alt_ss_n(ss_n_bus[1]), .alt_sck(sck_bus[1]),
    .alt_mosi(mosi_bus[1]), .alt_miso(miso_bus[1]), .vram_en_n, .vram_rd_n,
    .vram_wr_n, .vram_be_n, .vram_addr, .vram_data
  );

  sram_model #(.FILL_KEY(FILL_KEY)) u_sram (
    .cs_n(vram_en_n), .oe_n(vram_rd_n), .we_n(vram_wr_n), .be_n(vram_be_n),
    .addr(vram_addr), .data(vram_data)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and the byte reference.
  //////////////////////////////////////////////////////////////////////

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      byte_errors = byte_errors + 1;
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      level_errors = level_errors + 1;
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      count_errors = count_errors + 1;
      $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  // Byte held by a never-written SRAM word, lane by address bit 0.
  function automatic byte_t fill_byte(input byte_addr_t a);
    word_t w;
    w = word_t'({1'b0, a[15:1]}) ^ FILL_KEY;
    return a[0] ? w[15:8] : w[7:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // SPI master, mode 0, MSB first.
  //////////////////////////////////////////////////////////////////////

  // Lands 2 ns after the n-th rising edge.
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // One byte, MISO sampled just before each rising SCK.
  task automatic shift_byte(input int bus, input byte_t tx, output byte_t rx);
    for (int i = BYTE_W - 1; i >= 0; i--) begin
      mosi_bus[bus] = tx[i];
      wait_cycles(8);
      rx[i] = miso_bus[bus];
      sck_bus[bus] = 1'b1;
      wait_cycles(8);
      sck_bus[bus] = 1'b0;
    end
  endtask

  // Full frame. Writes expect a silent MISO, reads expect the reference bytes.
  task automatic spi_frame(input int bus, input logic is_wr, input byte_addr_t addr,
                           input int len, input logic keep);
    byte_t      tx;
    byte_t      rx;
    byte_addr_t a;
    string      pin;
    pin = (bus == 1) ? "alt_miso" : "miso";
    ss_n_bus[bus] = 1'b0;
    wait_cycles(8);
    // Low command bits are don't-care.
    shift_byte(bus, {is_wr, 7'($urandom)}, rx);
    check_byte(pin, 8'h00, rx);
    shift_byte(bus, addr[15:8], rx);
    check_byte(pin, 8'h00, rx);
    shift_byte(bus, addr[7:0], rx);
    check_byte(pin, 8'h00, rx);
    for (int k = 0; k < len; k++) begin
      a  = addr + byte_addr_t'(k);
      tx = byte_t'($urandom);
      shift_byte(bus, tx, rx);
      if (is_wr) begin
        check_byte(pin, 8'h00, rx);
        if (keep) ref_mem[a] = tx;
      end else begin
        check_byte(pin, ref_mem[a], rx);
      end
    end
    wait_cycles(8);
    ss_n_bus[bus] = 1'b1;
    wait_cycles(16);
  endtask

  // Random burst written, then read back from its start address.
  task automatic burst_round(input int bus);
    byte_addr_t addr;
    int         len;
    addr = byte_addr_t'($urandom);
    len  = 1 + int'($urandom % MAX_LEN);
    spi_frame(bus, 1'b1, addr, len, 1'b1);
    spi_frame(bus, 1'b0, addr, len, 1'b0);
  endtask

  // Odd lane first, then even lane, both lanes read after each.
  task automatic lane_round(input int bus);
    byte_addr_t word_base;
    word_base = byte_addr_t'($urandom) & 16'hfffe;
    spi_frame(bus, 1'b1, word_base | 16'h0001, 1, 1'b1);
    spi_frame(bus, 1'b0, word_base, 2, 1'b0);
    spi_frame(bus, 1'b1, word_base, 1, 1'b1);
    spi_frame(bus, 1'b0, word_base, 2, 1'b0);
  endtask

  // Primary write starts after the alternate bus owns the slave.
  // It ends one byte earlier, so it never wins the bus.
  // A second attempt overlaps the read-back, while the slave drives data.
  task automatic contention_round();
    byte_addr_t addr;
    addr = byte_addr_t'($urandom);
    fork
      spi_frame(1, 1'b1, addr, MAX_LEN, 1'b1);
      begin
        wait_cycles(4);
        spi_frame(0, 1'b1, addr, MAX_LEN - 1, 1'b0);
      end
    join
    fork
      spi_frame(1, 1'b0, addr, MAX_LEN, 1'b0);
      begin
        wait_cycles(4);
        spi_frame(0, 1'b1, addr, MAX_LEN - 1, 1'b0);
      end
    join
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pin monitor, sampled mid-cycle.
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (reset) begin
      run_len = 0;
    end else begin
      if (!vram_rd_n || !vram_wr_n) check_level("vram_en_n", 1'b0, vram_en_n);
      if (!vram_en_n) begin
        run_len = run_len + 1;
        check_level("vram_be_n one-hot low", 1'b1, ^vram_be_n);
        check_level("vram_addr[15]", 1'b0, vram_addr[15]);
      end else if (run_len != 0) begin
        check_count("access length", WAIT_CYCLES, run_len);
        run_len = 0;
      end
      // A read with the DUT also driving shows up as X.
      if (!vram_rd_n || !vram_wr_n) begin
        check_level("vram_data known", 1'b1, !$isunknown(vram_data));
      end else begin
        check_level("vram_data released", 1'b1, vram_data === {WORD_W{1'bz}});
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the SPI transactions did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed_val = 32'h6d16;
    void'($urandom(seed_val));
    for (int i = 0; i < 65536; i++) begin
      ref_mem[i] = fill_byte(byte_addr_t'(i));
    end
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    wait_cycles(2);
    // Idle levels after reset.
    check_level("vram_en_n", 1'b1, vram_en_n);
    check_level("vram_rd_n", 1'b1, vram_rd_n);
    check_level("vram_wr_n", 1'b1, vram_wr_n);
    check_level("vram_be_n[0]", 1'b1, vram_be_n[0]);
    check_level("vram_be_n[1]", 1'b1, vram_be_n[1]);
    check_level("vram_data high impedance", 1'b1, vram_data === {WORD_W{1'bz}});
    check_level("miso", 1'b0, miso_bus[0]);
    check_level("alt_miso", 1'b0, miso_bus[1]);
    repeat (N_BURSTS) burst_round(0);
    repeat (N_BURSTS) burst_round(1);
    lane_round(1);
    contention_round();
    wait_cycles(16);
    $display("Errors: %0d byte, %0d level, %0d count", byte_errors, level_errors,
             count_errors);
    if (byte_errors + level_errors + count_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
